/* Makefile */
# Verilator build and run for the retire stage testbench

OBJ = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f tb.f \
		--top-module retire_tb -Mdir $(OBJ) -o Vretire_tb

run: build
	./$(OBJ)/Vretire_tb | tee sim.log
	grep -q -F -- "*** PASSED ***" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f tb.f --top-module retire_tb
	verilator --lint-only +incdir+. isa_pkg.sv priv_pkg.sv load_align.sv \
		trap_control.sv retire.sv retire_top.sv --top-module retire_top

clean:
	rm -rf $(OBJ) sim.log

/* isa_pkg.sv */
// ISA operation encoding
// Operation codes of the in-order core; bits 5..3 of a code name the
// execution unit that handles it

`include "retire_params.svh"

package isa_pkg;

    // Execution unit, taken from the top three bits of the operation
    typedef enum logic [2:0] {
        ADDER_UNIT   = 3'd0,
        LOGICAL_UNIT = 3'd1,
        SHIFTER_UNIT = 3'd2,
        BRANCH_UNIT  = 3'd3,
        BYPASS_UNIT  = 3'd4,
        MEMORY_UNIT  = 3'd5,
        CSR_UNIT     = 3'd6
    } executionUnit_e;

    // Operation, grouped in blocks of eight per unit
    typedef enum logic [`OP_W-1:0] {
        NOP    = 6'd0,          // Adder unit
        ADD    = 6'd1,
        BEQ    = 6'd24,         // Branch unit
        BNE    = 6'd25,
        LB     = 6'd40,         // Memory unit, loads first
        LBU    = 6'd41,
        LH     = 6'd42,
        LHU    = 6'd43,
        LW     = 6'd44,
        SB     = 6'd45,         // Stores
        SH     = 6'd46,
        SW     = 6'd47,
        ECALL  = 6'd48,         // CSR unit, system instructions
        EBREAK = 6'd49,
        MRET   = 6'd50
    } iType_e;

endpackage

/* load_align.sv */
// Load alignment
// Picks the addressed byte or half-word out of the memory word and
// extends it to XLEN, with the sign bit for LB/LH and zeros for LBU/LHU.
// LW and every other operation see the word unchanged

`include "retire_params.svh"

module load_align (
    input  isa_pkg::iType_e   operation_i,      // Operation of the retiring instruction
    input  logic [1:0]        byte_offset_i,    // Low address bits of the load
    input  logic [`XLEN-1:0]  mem_data_i,       // Word read from memory
    output logic [`XLEN-1:0]  load_data_o       // Aligned and extended load value
);

    logic [7:0]  sel_byte;      // Byte picked by the offset
    logic [15:0] sel_half;      // Half picked by offset bit 1
    logic        is_byte;
    logic        is_half;
    logic        sign_ext;      // Signed forms only

    assign is_byte  = (operation_i == isa_pkg::LB) || (operation_i == isa_pkg::LBU);
    assign is_half  = (operation_i == isa_pkg::LH) || (operation_i == isa_pkg::LHU);
    assign sign_ext = (operation_i == isa_pkg::LB) || (operation_i == isa_pkg::LH);

    //////////////////////////////
    // Lane selection
    //////////////////////////////

    always_comb begin
        case (byte_offset_i)
            2'b11:   sel_byte = mem_data_i[31:24];
            2'b10:   sel_byte = mem_data_i[23:16];
            2'b01:   sel_byte = mem_data_i[15:8];
            default: sel_byte = mem_data_i[7:0];
        endcase
    end

    // Half-words sit on even addresses, bit 0 is ignored
    assign sel_half = byte_offset_i[1] ? mem_data_i[31:16] : mem_data_i[15:0];

    //////////////////////////////
    // Extension
    //////////////////////////////

    always_comb begin
        if (is_byte) begin
            load_data_o = {{(`XLEN-8){sign_ext & sel_byte[7]}}, sel_byte};
        end
        else if (is_half) begin
            load_data_o = {{(`XLEN-16){sign_ext & sel_half[15]}}, sel_half};
        end
        else begin
            load_data_o = mem_data_i;   // Full word or not a load
        end
    end

endmodule

/* priv_pkg.sv */
// Machine-mode privileged architecture codes
// Exception cause values reported to the CSR file on a trap

package priv_pkg;

    // Cause codes as written to mcause, NE means no exception
    typedef enum logic [3:0] {
        NE                  = 4'd0,
        ILLEGAL_INSTRUCTION = 4'd2,
        BREAKPOINT          = 4'd3,
        ECALL_FROM_MMODE    = 4'd11
    } exceptionCode_e;

endpackage

/* retire.sv */
// Retire core
// Checks the instruction tag against the retire tag and kills on mismatch.
// Live instructions write back, store, redirect fetch on a mispredict and
// raise the ranked trap. The retire tag steps after each redirect or trap
// so that younger wrong-path instructions are killed

`include "retire_params.svh"

module retire (
    input  logic                     clk,
    input  logic                     reset,

    input  logic [`XLEN-1:0]         pc_i,                   // PC of the retiring instruction
    input  logic [`XLEN-1:0]         result0_i,              // ALU result or store data
    input  logic [`XLEN-1:0]         result1_i,              // Branch target or memory address
    input  logic [`TAG_W-1:0]        tag_i,                  // Tag given at issue
    input  isa_pkg::iType_e          operation_i,
    input  logic                     write_enable_i,         // Register write requested
    input  logic [`WSTRB_W-1:0]      mem_write_enable_i,     // Store byte enables
    input  logic                     jump_i,                 // Branch resolved taken
    input  logic                     predicted_branch_i,     // Fetch predicted taken

    input  logic [`XLEN-1:0]         load_data_i,            // Aligned load value

    input  logic                     trap_raise_i,           // Ranked trap request, ungated
    input  priv_pkg::exceptionCode_e trap_code_i,
    input  logic                     mret_i,
    input  logic                     irq_ack_i,

    output logic                     regbank_write_enable_o,
    output logic [`XLEN-1:0]         regbank_data_o,
    output logic                     jump_o,                 // Redirect fetch
    output logic [`XLEN-1:0]         jump_target_o,
    output logic                     killed_o,
    output logic [`XLEN-1:0]         mem_write_address_o,
    output logic [`WSTRB_W-1:0]      mem_write_enable_o,
    output logic [`XLEN-1:0]         mem_data_o,
    output logic [`TAG_W-1:0]        current_retire_tag_o,
    output priv_pkg::exceptionCode_e exception_code_o,
    output logic                     raise_exception_o,
    output logic                     machine_return_o,
    output logic                     interrupt_ack_o
);

    logic [`TAG_W-1:0]       curr_tag;      // Only state in the stage
    logic                    killed;
    logic                    flow_change;   // Redirect or trap by a live instruction
    isa_pkg::executionUnit_e exec_unit;

    assign exec_unit            = isa_pkg::executionUnit_e'(operation_i[5:3]);
    assign current_retire_tag_o = curr_tag;

    //////////////////////////////
    // Kill
    //////////////////////////////

    // Wrong-path instructions still carry the previous tag
    assign killed   = (tag_i != curr_tag);
    assign killed_o = killed;

    //////////////////////////////
    // Write-back
    //////////////////////////////

    assign regbank_write_enable_o = write_enable_i & ~killed;
    assign regbank_data_o = (exec_unit == isa_pkg::MEMORY_UNIT) ? load_data_i : result0_i;

    //////////////////////////////
    // Mispredict redirect
    //////////////////////////////

    always_comb begin
        jump_o        = 1'b0;
        jump_target_o = '0;
        if (!killed) begin
            if (jump_i && !predicted_branch_i) begin
                // Taken but fetched fall-through, go to the target
                jump_o        = 1'b1;
                jump_target_o = result1_i;
            end
            else if (!jump_i && predicted_branch_i) begin
                // Not taken but fetched the target, back to pc_i
                jump_o        = 1'b1;
                jump_target_o = pc_i;
            end
        end
    end

    //////////////////////////////
    // Store gating
    //////////////////////////////

    always_comb begin
        if (mem_write_enable_i != '0 && !killed) begin
            mem_write_enable_o  = mem_write_enable_i;
            mem_write_address_o = result1_i;    // Address from the adder
            mem_data_o          = result0_i;
        end
        else begin
            mem_write_enable_o  = '0;           // Nothing reaches memory
            mem_write_address_o = '0;
            mem_data_o          = '0;
        end
    end

    //////////////////////////////
    // Trap outputs
    //////////////////////////////

    assign raise_exception_o = trap_raise_i & ~killed;
    assign machine_return_o  = mret_i & ~killed;
    assign interrupt_ack_o   = irq_ack_i & ~killed;
    assign exception_code_o  = killed ? priv_pkg::NE : trap_code_i;

    //////////////////////////////
    // Retire tag
    //////////////////////////////

    // All four terms are already kill-gated
    assign flow_change = jump_o | raise_exception_o | machine_return_o | interrupt_ack_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end
        else if (flow_change) begin
            curr_tag <= curr_tag + 1'b1;        // Wraps modulo 8
        end
    end

endmodule

/* retire_params.svh */
// Retire stage parameters
// Widths shared by the RTL and the testbench of the retire subsystem

`ifndef RETIRE_PARAMS_SVH
`define RETIRE_PARAMS_SVH

`define XLEN    32      // Data and address width
`define TAG_W   3       // Retire tag width, wraps modulo 8
`define OP_W    6       // Operation code width
`define WSTRB_W 4       // Byte write enables per word

`endif

/* retire_tb.sv */
// Retire stage testbench
// Applies a table of directed and random rows to the retire subsystem,
// tracks the retire tag in a small reference model and checks every
// output of each row before the next clock edge

`include "retire_params.svh"

module retire_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD_NS    = 4;
    localparam int RESET_CYCLES = 5;
    localparam int RANDOM_ROWS  = 16;

    localparam logic [1:0] TRAP_NONE  = 2'd0;   // Expected trap output kind
    localparam logic [1:0] TRAP_RAISE = 2'd1;
    localparam logic [1:0] TRAP_MRET  = 2'd2;
    localparam logic [1:0] TRAP_IRQ   = 2'd3;

    // One row of stimulus with its expected live results
    typedef struct packed {
        isa_pkg::iType_e          op;
        logic                     stale;        // Drive the previous tag
        logic                     we;
        logic [`WSTRB_W-1:0]      mwe;
        logic                     jump;
        logic                     pred;
        logic                     exc;
        logic                     irq;
        logic [`XLEN-1:0]         pc;
        logic [`XLEN-1:0]         r0;
        logic [`XLEN-1:0]         r1;
        logic [`XLEN-1:0]         mdata;
        logic [`XLEN-1:0]         exp_wb;
        logic [`XLEN-1:0]         exp_target;
        logic                     exp_jump;
        priv_pkg::exceptionCode_e exp_code;
        logic [1:0]               exp_trap;
    } row_t;

    logic                     clk;
    logic                     reset;
    logic [`XLEN-1:0]         instruction_i, pc_i, result0_i, result1_i, mem_data_i;
    logic [`TAG_W-1:0]        tag_i;
    logic [`WSTRB_W-1:0]      mem_write_enable_i;
    logic                     write_enable_i, jump_i, predicted_branch_i;
    logic                     exception_i, interrupt_pending_i;
    isa_pkg::iType_e          instruction_operation_i;
    logic                     regbank_write_enable_o, jump_o, killed_o;
    logic [`XLEN-1:0]         regbank_data_o, jump_target_o, mem_write_address_o, mem_data_o;
    logic [`WSTRB_W-1:0]      mem_write_enable_o;
    logic [`TAG_W-1:0]        current_retire_tag_o;
    priv_pkg::exceptionCode_e exception_code_o;
    logic                     raise_exception_o, machine_return_o, interrupt_ack_o;

    row_t              table_q[$];
    string             label_q[$];
    logic [`TAG_W-1:0] model_tag;               // Reference retire tag
    logic [31:0]       rng_state = 32'd13272;
    int                rows_total = 0;
    int                cur_row, row_errs, pass_count, fail_count;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i (
        .clk_o   (clk),
        .reset_o (reset)
    );

    retire_top dut_i (.*);

    //////////////////////////////
    // Reference helpers
    //////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;           // Xorshift32
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // ISA load value with the lane shifted down and then extended
    function automatic logic [`XLEN-1:0] expect_load(isa_pkg::iType_e op, logic [1:0] off,
                                                     logic [`XLEN-1:0] word);
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] h;
        b = word >> (8 * off);
        h = word >> (16 * off[1]);
        case (op)
            isa_pkg::LB:  return {{(`XLEN-8){b[7]}}, b[7:0]};
            isa_pkg::LBU: return {{(`XLEN-8){1'b0}}, b[7:0]};
            isa_pkg::LH:  return {{(`XLEN-16){h[15]}}, h[15:0]};
            isa_pkg::LHU: return {{(`XLEN-16){1'b0}}, h[15:0]};
            default:      return word;
        endcase
    endfunction

    function automatic row_t idle_row();
        row_t r;
        r          = '0;
        r.op       = isa_pkg::NOP;
        r.exp_code = priv_pkg::NE;
        return r;
    endfunction

    //////////////////////////////
    // Table builders
    //////////////////////////////

    task automatic push_row(input row_t r, input string label);
        table_q.push_back(r);
        label_q.push_back(label);
    endtask

    task automatic add_load(input isa_pkg::iType_e op, input logic [1:0] off,
                            input logic [`XLEN-1:0] word, input logic [`XLEN-1:0] exp);
        row_t r;
        r        = idle_row();
        r.op     = op;
        r.we     = 1'b1;
        r.r0     = 32'h0bad_0bad;               // Must not reach write-back
        r.r1     = {30'h0000_0800, off};
        r.mdata  = word;
        r.exp_wb = exp;
        push_row(r, "load");
    endtask

    task automatic add_alu(input isa_pkg::iType_e op, input logic we,
                           input logic [`XLEN-1:0] r0, input logic stale);
        row_t r;
        r        = idle_row();
        r.op     = op;
        r.we     = we;
        r.r0     = r0;
        r.mdata  = 32'hffff_0000;               // Ignored for ALU ops
        r.stale  = stale;
        r.exp_wb = r0;
        push_row(r, "alu");
    endtask

    task automatic add_branch(input isa_pkg::iType_e op, input logic jump, input logic pred,
                              input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] r1,
                              input logic stale, input logic exp_jump,
                              input logic [`XLEN-1:0] exp_target);
        row_t r;
        r            = idle_row();
        r.op         = op;
        r.jump       = jump;
        r.pred       = pred;
        r.pc         = pc;
        r.r1         = r1;
        r.mdata      = 32'hffff_0000;           // Ignored for branches
        r.stale      = stale;
        r.exp_jump   = exp_jump;
        r.exp_target = exp_target;
        push_row(r, "branch");
    endtask

    task automatic add_store(input isa_pkg::iType_e op, input logic [`WSTRB_W-1:0] mwe,
                             input logic [`XLEN-1:0] r0, input logic [`XLEN-1:0] r1,
                             input logic stale);
        row_t r;
        r        = idle_row();
        r.op     = op;
        r.mwe    = mwe;
        r.r0     = r0;
        r.r1     = r1;
        r.mdata  = 32'h5eed_cafe;
        r.stale  = stale;
        r.exp_wb = 32'h5eed_cafe;               // Memory unit passes the word through
        push_row(r, "store");
    endtask

    task automatic add_trap(input isa_pkg::iType_e op, input logic exc, input logic irq,
                            input logic stale, input priv_pkg::exceptionCode_e exp_code,
                            input logic [1:0] exp_trap);
        row_t r;
        r          = idle_row();
        r.op       = op;
        r.exc      = exc;
        r.irq      = irq;
        r.r0       = 32'h0000_0aaa;
        r.stale    = stale;
        r.exp_wb   = 32'h0000_0aaa;
        r.exp_code = exp_code;
        r.exp_trap = exp_trap;
        push_row(r, "trap");
    endtask

    task automatic build_table();
        logic [31:0]     sel;
        logic [31:0]     word;
        isa_pkg::iType_e op;
        // Directed loads of 8f7e_41c3 at every lane
        add_load(isa_pkg::LB,  2'd0, 32'h8f7e_41c3, 32'hffff_ffc3);
        add_load(isa_pkg::LB,  2'd1, 32'h8f7e_41c3, 32'h0000_0041);
        add_load(isa_pkg::LB,  2'd2, 32'h8f7e_41c3, 32'h0000_007e);
        add_load(isa_pkg::LB,  2'd3, 32'h8f7e_41c3, 32'hffff_ff8f);
        add_load(isa_pkg::LBU, 2'd0, 32'h8f7e_41c3, 32'h0000_00c3);
        add_load(isa_pkg::LBU, 2'd1, 32'h8f7e_41c3, 32'h0000_0041);
        add_load(isa_pkg::LBU, 2'd2, 32'h8f7e_41c3, 32'h0000_007e);
        add_load(isa_pkg::LBU, 2'd3, 32'h8f7e_41c3, 32'h0000_008f);
        add_load(isa_pkg::LH,  2'd0, 32'h8f7e_41c3, 32'h0000_41c3);
        add_load(isa_pkg::LH,  2'd1, 32'h8f7e_41c3, 32'h0000_41c3);
        add_load(isa_pkg::LH,  2'd2, 32'h8f7e_41c3, 32'hffff_8f7e);
        add_load(isa_pkg::LH,  2'd3, 32'h8f7e_41c3, 32'hffff_8f7e);
        add_load(isa_pkg::LHU, 2'd0, 32'h8f7e_41c3, 32'h0000_41c3);
        add_load(isa_pkg::LHU, 2'd1, 32'h8f7e_41c3, 32'h0000_41c3);
        add_load(isa_pkg::LHU, 2'd2, 32'h8f7e_41c3, 32'h0000_8f7e);
        add_load(isa_pkg::LHU, 2'd3, 32'h8f7e_41c3, 32'h0000_8f7e);
        add_load(isa_pkg::LW,  2'd0, 32'h8f7e_41c3, 32'h8f7e_41c3);
        add_load(isa_pkg::LW,  2'd1, 32'h8f7e_41c3, 32'h8f7e_41c3);
        add_load(isa_pkg::LW,  2'd2, 32'h8f7e_41c3, 32'h8f7e_41c3);
        add_load(isa_pkg::LW,  2'd3, 32'h8f7e_41c3, 32'h8f7e_41c3);
        add_alu(isa_pkg::ADD, 1'b1, 32'h1234_5678, 1'b0);
        add_alu(isa_pkg::ADD, 1'b0, 32'hdead_beef, 1'b0);
        add_alu(isa_pkg::NOP, 1'b0, 32'h0000_0000, 1'b0);
        // Mispredicts with stale rows right after a redirect
        add_branch(isa_pkg::BEQ, 1'b1, 1'b0, 32'h100, 32'h240, 1'b0, 1'b1, 32'h240);
        add_alu(isa_pkg::ADD, 1'b1, 32'h1111_1111, 1'b1);
        add_branch(isa_pkg::BNE, 1'b1, 1'b0, 32'h104, 32'h300, 1'b1, 1'b1, 32'h300);
        add_alu(isa_pkg::ADD, 1'b1, 32'h2222_2222, 1'b0);
        add_branch(isa_pkg::BNE, 1'b0, 1'b1, 32'h104, 32'h380, 1'b0, 1'b1, 32'h104);
        add_branch(isa_pkg::BEQ, 1'b1, 1'b1, 32'h108, 32'h400, 1'b0, 1'b0, 32'h0);
        add_branch(isa_pkg::BEQ, 1'b0, 1'b0, 32'h10c, 32'h500, 1'b0, 1'b0, 32'h0);
        add_store(isa_pkg::SW, 4'hf, 32'h55aa_1234, 32'h0000_2000, 1'b0);
        add_store(isa_pkg::SB, 4'h2, 32'h0000_a500, 32'h0000_2001, 1'b0);
        add_store(isa_pkg::SH, 4'hc, 32'h7777_0000, 32'h0000_2002, 1'b1);
        add_store(isa_pkg::SW, 4'h0, 32'h9999_9999, 32'h0000_2004, 1'b0);
        // Each live trap steps the tag and the last one wraps it to 0
        add_trap(isa_pkg::ECALL,  1'b1, 1'b1, 1'b0, priv_pkg::ILLEGAL_INSTRUCTION, TRAP_RAISE);
        add_trap(isa_pkg::ECALL,  1'b0, 1'b1, 1'b0, priv_pkg::ECALL_FROM_MMODE, TRAP_RAISE);
        add_trap(isa_pkg::EBREAK, 1'b0, 1'b1, 1'b0, priv_pkg::BREAKPOINT, TRAP_RAISE);
        add_trap(isa_pkg::MRET,   1'b0, 1'b1, 1'b0, priv_pkg::NE, TRAP_MRET);
        add_trap(isa_pkg::ECALL,  1'b0, 1'b0, 1'b1, priv_pkg::ECALL_FROM_MMODE, TRAP_RAISE);
        add_trap(isa_pkg::NOP,    1'b0, 1'b1, 1'b0, priv_pkg::NE, TRAP_IRQ);
        add_trap(isa_pkg::EBREAK, 1'b0, 1'b0, 1'b0, priv_pkg::BREAKPOINT, TRAP_RAISE);
        add_alu(isa_pkg::ADD, 1'b1, 32'h3333_3333, 1'b0);
        for (int n = 0; n < RANDOM_ROWS; n++) begin
            sel  = next_random();
            word = next_random();
            case (sel % 5)
                0:       op = isa_pkg::LB;
                1:       op = isa_pkg::LBU;
                2:       op = isa_pkg::LH;
                3:       op = isa_pkg::LHU;
                default: op = isa_pkg::LW;
            endcase
            add_load(op, sel[9:8], word, expect_load(op, sel[9:8], word));
        end
    endtask

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s row %0d expected %h got %h", name, cur_row, exp, act);
            row_errs++;
        end
    endtask

    task automatic check_code(input string name, input priv_pkg::exceptionCode_e exp,
                              input priv_pkg::exceptionCode_e act);
        if (act !== exp) begin
            $display("MISMATCH %s row %0d expected %h got %h", name, cur_row, exp, act);
            row_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s row %0d expected %h got %h", name, cur_row, exp, act);
            row_errs++;
        end
    endtask

    task automatic check_tag(input string name, input logic [`TAG_W-1:0] exp,
                             input logic [`TAG_W-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s row %0d expected %h got %h", name, cur_row, exp, act);
            row_errs++;
        end
    endtask

    task automatic check_strobe(input string name, input logic [`WSTRB_W-1:0] exp,
                                input logic [`WSTRB_W-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s row %0d expected %h got %h", name, cur_row, exp, act);
            row_errs++;
        end
    endtask

    //////////////////////////////
    // Drive and check
    //////////////////////////////

    task automatic drive_row(input row_t r);
        instruction_operation_i = r.op;
        tag_i                   = r.stale ? model_tag - 1'b1 : model_tag;  // Old tag kills
        write_enable_i          = r.we;
        mem_write_enable_i      = r.mwe;
        jump_i                  = r.jump;
        predicted_branch_i      = r.pred;
        exception_i             = r.exc;
        interrupt_pending_i     = r.irq;
        pc_i                    = r.pc;
        result0_i               = r.r0;
        result1_i               = r.r1;
        mem_data_i              = r.mdata;
    endtask

    task automatic check_row(input row_t r);
        logic live;
        logic st;
        live = ~r.stale;
        st   = live && (r.mwe != '0);
        check_bit("killed_o", r.stale, killed_o);
        check_tag("current_retire_tag_o", model_tag, current_retire_tag_o);
        check_bit("regbank_write_enable_o", r.we & live, regbank_write_enable_o);
        check_word("regbank_data_o", r.exp_wb, regbank_data_o);
        check_bit("jump_o", r.exp_jump & live, jump_o);
        check_word("jump_target_o", live ? r.exp_target : '0, jump_target_o);
        check_strobe("mem_write_enable_o", st ? r.mwe : '0, mem_write_enable_o);
        check_word("mem_write_address_o", st ? r.r1 : '0, mem_write_address_o);
        check_word("mem_data_o", st ? r.r0 : '0, mem_data_o);
        check_code("exception_code_o", live ? r.exp_code : priv_pkg::NE, exception_code_o);
        check_bit("raise_exception_o", live && r.exp_trap == TRAP_RAISE, raise_exception_o);
        check_bit("machine_return_o", live && r.exp_trap == TRAP_MRET, machine_return_o);
        check_bit("interrupt_ack_o", live && r.exp_trap == TRAP_IRQ, interrupt_ack_o);
        // A live redirect or trap steps the tag at the next edge
        if (live && (r.exp_jump || r.exp_trap != TRAP_NONE)) begin
            model_tag = model_tag + 1'b1;
        end
    endtask

    task automatic report_row(input string label);
        $display("test %0d %s: %s", cur_row, label, (row_errs == 0) ? "ok" : "FAIL");
        if (row_errs == 0) begin
            pass_count++;
        end
        else begin
            fail_count++;
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        instruction_i           = 32'h0000_0013;    // Idle inputs with a NOP at tag 0
        instruction_operation_i = isa_pkg::NOP;
        tag_i                   = '0;
        pc_i                    = '0;
        result0_i               = '0;
        result1_i               = '0;
        mem_data_i              = '0;
        mem_write_enable_i      = '0;
        write_enable_i          = 1'b0;
        jump_i                  = 1'b0;
        predicted_branch_i      = 1'b0;
        exception_i             = 1'b0;
        interrupt_pending_i     = 1'b0;
        model_tag               = '0;
        pass_count              = 0;
        fail_count              = 0;
        build_table();
        rows_total = table_q.size();

        wait (reset == 1'b0);
        @(posedge clk);
        #3;
        cur_row  = 0;
        row_errs = 0;
        check_row(idle_row());                      // All controls idle out of reset
        report_row("reset");

        for (int i = 0; i < table_q.size(); i++) begin
            @(posedge clk);
            #1;
            drive_row(table_q[i]);
            #2;
            cur_row  = i + 1;
            row_errs = 0;
            check_row(table_q[i]);
            report_row(label_q[i]);
        end

        $display("Tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end
        else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (rows_total != 0);
        #((rows_total + RESET_CYCLES + 20) * PERIOD_NS);
        $display("Timeout, the run did not finish within the expected time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* retire_top.sv */
// Retire subsystem top
// Load alignment and trap decode run side by side on the raw inputs,
// the retire core merges their results under the kill condition

`include "retire_params.svh"

module retire_top (
    input  logic                     clk,
    input  logic                     reset,

    input  logic [`XLEN-1:0]         instruction_i,          // Raw instruction word, not decoded here
    input  logic [`XLEN-1:0]         pc_i,
    input  logic [`XLEN-1:0]         result0_i,
    input  logic [`XLEN-1:0]         result1_i,
    input  logic [`TAG_W-1:0]        tag_i,
    input  logic [`WSTRB_W-1:0]      mem_write_enable_i,
    input  logic                     write_enable_i,
    input  logic                     jump_i,
    input  logic                     predicted_branch_i,
    input  isa_pkg::iType_e          instruction_operation_i,
    input  logic                     exception_i,
    input  logic [`XLEN-1:0]         mem_data_i,             // Load word from memory
    input  logic                     interrupt_pending_i,

    output logic                     regbank_write_enable_o,
    output logic [`XLEN-1:0]         regbank_data_o,
    output logic                     jump_o,
    output logic [`XLEN-1:0]         jump_target_o,
    output logic                     killed_o,
    output logic [`XLEN-1:0]         mem_write_address_o,
    output logic [`WSTRB_W-1:0]      mem_write_enable_o,
    output logic [`XLEN-1:0]         mem_data_o,
    output logic [`TAG_W-1:0]        current_retire_tag_o,
    output priv_pkg::exceptionCode_e exception_code_o,
    output logic                     raise_exception_o,
    output logic                     machine_return_o,
    output logic                     interrupt_ack_o
);

    logic [`XLEN-1:0]         load_data;
    logic                     trap_raise;
    priv_pkg::exceptionCode_e trap_code;
    logic                     trap_mret;
    logic                     trap_irq_ack;

    // Byte lane comes from the low bits of the computed address
    load_align load_align_i (
        .operation_i   (instruction_operation_i),
        .byte_offset_i (result1_i[1:0]),
        .mem_data_i    (mem_data_i),
        .load_data_o   (load_data)
    );

    trap_control trap_control_i (
        .exception_i         (exception_i),
        .operation_i         (instruction_operation_i),
        .interrupt_pending_i (interrupt_pending_i),
        .trap_raise_o        (trap_raise),
        .trap_code_o         (trap_code),
        .mret_o              (trap_mret),
        .irq_ack_o           (trap_irq_ack)
    );

    retire retire_i (
        .clk                    (clk),
        .reset                  (reset),
        .pc_i                   (pc_i),
        .result0_i              (result0_i),
        .result1_i              (result1_i),
        .tag_i                  (tag_i),
        .operation_i            (instruction_operation_i),
        .write_enable_i         (write_enable_i),
        .mem_write_enable_i     (mem_write_enable_i),
        .jump_i                 (jump_i),
        .predicted_branch_i     (predicted_branch_i),
        .load_data_i            (load_data),
        .trap_raise_i           (trap_raise),
        .trap_code_i            (trap_code),
        .mret_i                 (trap_mret),
        .irq_ack_i              (trap_irq_ack),
        .regbank_write_enable_o (regbank_write_enable_o),
        .regbank_data_o         (regbank_data_o),
        .jump_o                 (jump_o),
        .jump_target_o          (jump_target_o),
        .killed_o               (killed_o),
        .mem_write_address_o    (mem_write_address_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_data_o             (mem_data_o),
        .current_retire_tag_o   (current_retire_tag_o),
        .exception_code_o       (exception_code_o),
        .raise_exception_o      (raise_exception_o),
        .machine_return_o       (machine_return_o),
        .interrupt_ack_o        (interrupt_ack_o)
    );

endmodule

/* tb.f */
+incdir+.
isa_pkg.sv
priv_pkg.sv
load_align.sv
trap_control.sv
retire.sv
retire_top.sv
tb_clock_gen.sv
retire_tb.sv

/* tb_clock_gen.sv */
// Testbench clock and reset
// Free-running clock plus a synchronous reset held for a fixed number
// of rising edges after time zero

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,     // Clock period
    parameter int RESET_CYCLES = 5      // Rising edges with reset high
) (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial clk_o = 1'b0;
    always #(PERIOD_NS / 2) clk_o = ~clk_o;

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 reset_o = 1'b0;                      // Release just after the edge
    end

endmodule

/* trap_control.sv */
// Trap control
// Ranks illegal instruction, ECALL, EBREAK, MRET and a pending interrupt
// into one trap request. At most one output is set, the cause code is
// NE unless an exception is raised. No kill gating here

module trap_control (
    input  logic                     exception_i,         // Illegal instruction from decode
    input  isa_pkg::iType_e          operation_i,         // Operation of the retiring instruction
    input  logic                     interrupt_pending_i, // Interrupt waiting in the CSR file
    output logic                     trap_raise_o,        // Synchronous exception
    output priv_pkg::exceptionCode_e trap_code_o,         // Cause for trap_raise_o
    output logic                     mret_o,              // Return from machine trap
    output logic                     irq_ack_o            // Interrupt taken
);

    logic is_ecall;
    logic is_ebreak;
    logic is_mret;

    assign is_ecall  = (operation_i == isa_pkg::ECALL);
    assign is_ebreak = (operation_i == isa_pkg::EBREAK);
    assign is_mret   = (operation_i == isa_pkg::MRET);

    //////////////////////////////
    // Priority decode
    //////////////////////////////

    always_comb begin
        // Defaults, nothing to do
        trap_raise_o = 1'b0;
        trap_code_o  = priv_pkg::NE;
        mret_o       = 1'b0;
        irq_ack_o    = 1'b0;

        if (exception_i) begin                      // Highest, decode fault
            trap_raise_o = 1'b1;
            trap_code_o  = priv_pkg::ILLEGAL_INSTRUCTION;
        end
        else if (is_ecall) begin
            trap_raise_o = 1'b1;
            trap_code_o  = priv_pkg::ECALL_FROM_MMODE;
        end
        else if (is_ebreak) begin
            trap_raise_o = 1'b1;
            trap_code_o  = priv_pkg::BREAKPOINT;
        end
        else if (is_mret) begin
            mret_o = 1'b1;                          // Not an exception, code stays NE
        end
        else if (interrupt_pending_i) begin
            // Interrupt only taken on an otherwise ordinary instruction
            irq_ack_o = 1'b1;
        end
    end

endmodule
